// File: common/st_link_pkg.sv
////////////////////////////////////////////////////////////
// Streaming link widths and vector types, the link word
// and PHY beat structs, online qualifier FSM states
////////////////////////////////////////////////////////////

package st_link_pkg;

  ////////////////////////////////////////////////////////////
  // Widths

  // User stream
  localparam int DATA_W = 256;
  localparam int KEEP_W = 32;

  // Link word is tlast + keep + data
  localparam int WORD_W = 1 + KEEP_W + DATA_W;

  // One PHY channel
  localparam int PHY_W = 160;

  // Push and strobe take the two low bits of channel 0
  localparam int PHY0_WORD_W = PHY_W - 2;
  // Remainder of the word goes to the low end of channel 1
  localparam int PHY1_WORD_W = WORD_W - PHY0_WORD_W;

  // Credit and status counters
  localparam int CRED_W     = 8;
  localparam int PUSH_CNT_W = 8;
  localparam int DBG_W      = 32;

  // Online delay counts
  localparam int DLY_W = 16;

  // Alignment strobe, one pulse per period while offline
  localparam int STB_PERIOD = 8;
  localparam int STB_CNT_W  = $clog2(STB_PERIOD);

  ////////////////////////////////////////////////////////////
  // Vector types

  typedef logic [DATA_W-1:0] st_data_t;
  typedef logic [KEEP_W-1:0] st_keep_t;
  typedef logic [CRED_W-1:0] cred_t;
  typedef logic [DLY_W-1:0]  dly_t;
  typedef logic [PHY_W-1:0]  phy_t;

  ////////////////////////////////////////////////////////////
  // Structs and enums

  // Link word, tlast in the top bit
  typedef struct packed {
    logic     tlast;
    st_keep_t keep;
    st_data_t data;
  } st_word_t;

  // Beat handed to the PHY mapper
  typedef struct packed {
    st_word_t word;
    logic     push;
    logic     stb;
  } tx_beat_t;

  // Online qualifier states
  typedef enum logic [1:0] {
    OFFLINE,
    COUNT,
    ONLINE
  } sync_state_e;

endpackage

// File: ll/ll_auto_sync.sv
////////////////////////////////////////////////////////////
// Online qualifier delay FSMs and alignment strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ll_auto_sync (
  input  logic              clk_wr,
  input  logic              rst,
  input  logic              tx_online,
  input  logic              rx_online,
  input  st_link_pkg::dly_t delay_x_value,
  input  st_link_pkg::dly_t delay_y_value,
  output logic              tx_online_delay,
  output logic              rx_online_delay,
  output logic              tx_auto_stb
);
  import st_link_pkg::*;

  // Slot 0 qualifies rx_online, slot 1 qualifies tx_online
  logic [1:0]           qual_in;
  logic [1:0]           qual_out;
  dly_t                 qual_dly [2];
  logic [STB_CNT_W-1:0] phase_q;

  assign qual_dly[0] = delay_x_value;
  assign qual_dly[1] = delay_y_value;

  // Transmit side waits for the delayed receive qualifier
  assign qual_in[0] = rx_online;
  assign qual_in[1] = tx_online & qual_out[0];

  ////////////////////////////////////////////////////////////
  // Delay FSMs

  for (genvar g = 0; g < 2; g++) begin : g_qual
    sync_state_e state_q;
    dly_t        cnt_q;

    always_ff @(posedge clk_wr) begin
      if (rst) begin
        state_q <= OFFLINE;
        cnt_q   <= '0;
      end else if (!qual_in[g]) begin
        // Input low drops the qualifier next cycle
        state_q <= OFFLINE;
      end else begin
        case (state_q)
          OFFLINE: begin
            // First cycle the input is seen high
            cnt_q <= qual_dly[g];
            if (qual_dly[g] == '0) begin
              state_q <= ONLINE;
            end else begin
              state_q <= COUNT;
            end
          end
          COUNT: begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == dly_t'(1)) begin
              state_q <= ONLINE;
            end
          end
          ONLINE: begin
            state_q <= ONLINE;
          end
          default: begin
            state_q <= OFFLINE;
          end
        endcase
      end
    end

    assign qual_out[g] = (state_q == ONLINE);
  end

  assign rx_online_delay = qual_out[0];
  assign tx_online_delay = qual_out[1];

  ////////////////////////////////////////////////////////////
  // Alignment strobe

  // Free-running phase, wraps every STB_PERIOD cycles
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      phase_q <= '0;
    end else if (phase_q == STB_CNT_W'(STB_PERIOD - 1)) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // Periodic pulse while offline, held high once online
  assign tx_auto_stb = tx_online_delay | (phase_q == '0);

endmodule

// File: ll/ll_transmit.sv
////////////////////////////////////////////////////////////
// One-entry transmit register, credit counter,
// push strobe and debug status word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ll_transmit (
  input  logic                          clk_wr,
  input  logic                          rst,
  input  logic                          tx_online,
  input  st_link_pkg::cred_t            init_credit,
  input  st_link_pkg::st_word_t         user_word,
  input  logic                          user_valid,
  output logic                          user_ready,
  input  logic                          rx_credit,
  output st_link_pkg::tx_beat_t         tx_beat,
  output logic [st_link_pkg::DBG_W-1:0] debug_status
);
  import st_link_pkg::*;

  // Delayed online, for the credit load edge
  logic                  online_q;
  logic                  accept;
  cred_t                 cred_q;
  logic [PUSH_CNT_W-1:0] push_cnt_q;

  // Output register
  st_word_t              word_q;
  logic                  push_q;

  ////////////////////////////////////////////////////////////
  // User handshake

  // Register drains every cycle, so only online and credits gate ready
  assign user_ready = tx_online & (cred_q != '0);
  assign accept     = user_valid & user_ready;

  ////////////////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      online_q <= 1'b0;
      cred_q   <= '0;
    end else begin
      online_q <= tx_online;
      if (!tx_online) begin
        // Pool is empty while offline
        cred_q <= '0;
      end else if (!online_q) begin
        // Cycle after online rises
        cred_q <= init_credit;
      end else begin
        case ({accept, rx_credit})
          2'b10: begin
            cred_q <= cred_q - 1'b1;
          end
          2'b01: begin
            cred_q <= cred_q + 1'b1;
          end
          default: begin
            // Take and return cancel out
            cred_q <= cred_q;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Transmit register and push strobe

  // One pulse per accepted word
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      push_q <= 1'b0;
    end else begin
      push_q <= accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      word_q <= user_word;
    end
  end

  // Strobe lane filled in at the top from auto sync
  assign tx_beat.word = word_q;
  assign tx_beat.push = push_q;
  assign tx_beat.stb  = 1'b0;

  ////////////////////////////////////////////////////////////
  // Debug status

  // Words taken, wraps at 256
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      push_cnt_q <= '0;
    end else if (accept) begin
      push_cnt_q <= push_cnt_q + 1'b1;
    end
  end

  // Credits low byte, pushes next byte, online at bit 16
  assign debug_status = {
    {(DBG_W - PUSH_CNT_W - CRED_W - 1){1'b0}},
    tx_online,
    push_cnt_q,
    cred_q
  };

endmodule

// File: verilog/st_phy_map.sv
////////////////////////////////////////////////////////////
// Link word to PHY lane split, credit return sample
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_phy_map (
  input  logic                  clk_wr,
  input  logic                  rst,
  input  st_link_pkg::tx_beat_t tx_beat,
  output st_link_pkg::phy_t     tx_phy0,
  output st_link_pkg::phy_t     tx_phy1,
  input  st_link_pkg::phy_t     rx_phy0,
  output logic                  rx_credit
);
  import st_link_pkg::*;

  logic [WORD_W-1:0] word_bits;
  phy_t              phy0_d;
  phy_t              phy1_d;

  assign word_bits = tx_beat.word;

  ////////////////////////////////////////////////////////////
  // Lane split

  // Channel 0 is push at bit 0, strobe at bit 1, low word bits above
  assign phy0_d = {word_bits[PHY0_WORD_W-1:0], tx_beat.stb, tx_beat.push};

  // Channel 1 is upper word bits, zero padded
  assign phy1_d = {
    {(PHY_W - PHY1_WORD_W){1'b0}},
    word_bits[WORD_W-1:PHY0_WORD_W]
  };

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= phy0_d;
      tx_phy1 <= phy1_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Credit return

  // One pulse per credit on bit 0
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_credit <= 1'b0;
    end else begin
      rx_credit <= rx_phy0[0];
    end
  end

endmodule

// File: verilog/st_link_master_top.sv
////////////////////////////////////////////////////////////
// Streaming link transmit top, user stream pack,
// auto sync, transmit and PHY mapping blocks
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_link_master_top (
  input  logic                          clk_wr,
  input  logic                          rst,

  // Link control
  input  logic                          tx_online,
  input  logic                          rx_online,
  input  st_link_pkg::cred_t            init_st_credit,

  // PHY channels
  output st_link_pkg::phy_t             tx_phy0,
  input  st_link_pkg::phy_t             rx_phy0,
  output st_link_pkg::phy_t             tx_phy1,
  input  st_link_pkg::phy_t             rx_phy1,

  // AXI-stream user channel
  input  st_link_pkg::st_keep_t         user_tkeep,
  input  st_link_pkg::st_data_t         user_tdata,
  input  logic                          user_tlast,
  input  logic                          user_tvalid,
  output logic                          user_tready,

  // Status
  output logic [st_link_pkg::DBG_W-1:0] tx_st_debug_status,

  // Online delays, receive then transmit
  input  st_link_pkg::dly_t             delay_x_value,
  input  st_link_pkg::dly_t             delay_y_value
);
  import st_link_pkg::*;

  st_word_t user_word;
  tx_beat_t tx_beat;
  tx_beat_t phy_beat;
  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_auto_stb;
  logic     rx_credit;

  // Pack the stream into a link word
  assign user_word = '{tlast: user_tlast, keep: user_tkeep, data: user_tdata};

  ////////////////////////////////////////////////////////////
  // Online sequencing

  ll_auto_sync i_auto_sync (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_stb     (tx_auto_stb)
  );

  ////////////////////////////////////////////////////////////
  // Transmit and credits

  ll_transmit i_transmit (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .tx_online    (tx_online_delay),
    .init_credit  (init_st_credit),
    .user_word    (user_word),
    .user_valid   (user_tvalid),
    .user_ready   (user_tready),
    .rx_credit    (rx_credit),
    .tx_beat      (tx_beat),
    .debug_status (tx_st_debug_status)
  );

  // Merge the alignment strobe into the beat
  assign phy_beat = '{word: tx_beat.word, push: tx_beat.push, stb: tx_auto_stb};

  ////////////////////////////////////////////////////////////
  // PHY mapping, rx_phy1 is reserved

  st_phy_map i_phy_map (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .tx_beat   (phy_beat),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .rx_phy0   (rx_phy0),
    .rx_credit (rx_credit)
  );

endmodule

// File: bench/st_link_master_asserts.sv
////////////////////////////////////////////////////////////
// Bound checks on the link transmit top: online timing,
// alignment strobe, lane data, credits and status word
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module st_link_master_asserts (
  input logic                           clk_wr,
  input logic                           rst,
  input logic                           tx_online,
  input logic                           rx_online,
  input logic                           tx_online_delay,
  input logic                           rx_online_delay,
  input st_link_pkg::cred_t             init_st_credit,
  input st_link_pkg::dly_t              delay_x_value,
  input st_link_pkg::dly_t              delay_y_value,
  input logic [st_link_pkg::WORD_W-1:0] user_word,
  input logic                           user_tvalid,
  input logic                           user_tready,
  input st_link_pkg::phy_t              tx_phy0,
  input st_link_pkg::phy_t              tx_phy1,
  input st_link_pkg::phy_t              rx_phy0,
  input logic [st_link_pkg::DBG_W-1:0]  tx_st_debug_status
);
  import st_link_pkg::*;

  // Failed assertion count
  int unsigned           fail_cnt = 0;

  logic                  hs;
  logic                  hs_d1;
  logic                  hs_d2;
  logic [WORD_W-1:0]     word_d1;
  logic [WORD_W-1:0]     word_d2;
  logic                  online_d;
  logic                  ret_d;
  cred_t                 exp_cred;
  logic [PUSH_CNT_W-1:0] exp_push;
  int unsigned           rx_wait;
  int unsigned           tx_wait;

  assign hs = user_tvalid & user_tready;

  ////////////////////////////////////////////////////////////
  // Expected state

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      hs_d1    <= 1'b0;
      hs_d2    <= 1'b0;
      online_d <= 1'b0;
      ret_d    <= 1'b0;
      exp_cred <= '0;
      exp_push <= '0;
      rx_wait  <= 0;
      tx_wait  <= 0;
    end else begin
      hs_d1    <= hs;
      hs_d2    <= hs_d1;
      online_d <= tx_online_delay;
      // Returned credit lands one cycle after the PHY bit
      ret_d    <= rx_phy0[0];
      exp_push <= exp_push + hs;
      // Cycles each online input has been seen high
      rx_wait  <= rx_online ? rx_wait + 1 : 0;
      tx_wait  <= (tx_online && rx_online_delay) ? tx_wait + 1 : 0;
      if (!tx_online_delay) begin
        exp_cred <= '0;
      end else if (!online_d) begin
        exp_cred <= init_st_credit;
      end else begin
        exp_cred <= exp_cred + ret_d - hs;
      end
    end
  end

  // Two-cycle word delay to the PHY
  always_ff @(posedge clk_wr) begin
    word_d1 <= user_word;
    word_d2 <= word_d1;
  end

  ////////////////////////////////////////////////////////////
  // Reset and online timing

  a_reset_clear: assert property (@(posedge clk_wr)
    $fell(rst) |-> !user_tready && tx_phy0 == '0 && tx_phy1 == '0)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t ready,|tx_phy0,|tx_phy1 got %b exp 000", $time,
        $sampled({user_tready, |tx_phy0, |tx_phy1}));
    end

  a_rx_delay: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(rx_online_delay) |-> rx_wait == delay_x_value + 1)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t rx_online_delay rise cycle got %0d exp %0d", $time,
        $sampled(rx_wait), delay_x_value + 1);
    end

  a_tx_delay: assert property (@(posedge clk_wr) disable iff (rst)
    $rose(tx_online_delay) |-> tx_wait == delay_y_value + 1)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t tx_online_delay rise cycle got %0d exp %0d", $time,
        $sampled(tx_wait), delay_y_value + 1);
    end

  // Ready follows the online drop one cycle later
  a_offline_drop: assert property (@(posedge clk_wr) disable iff (rst)
    !tx_online |=> !user_tready)
    else begin
      fail_cnt++;
      $error("[FAIL] %0t user_tready got %b exp 0", $time, $sampled(user_tready));
    end

  ////////////////////////////////////////////////////////////
  // Alignment strobe

  a_stb_offline: assert property (@(posedge clk_wr) disable iff (rst || tx_online_delay)
    tx_phy0[1] && !$past(tx_online_delay) |=>
      !tx_phy0[1] [*(STB_PERIOD - 1)] ##1 tx_phy0[1])
    else begin
      fail_cnt++;
      $error("[FAIL] %0t tx_phy0[1] got %b exp %b", $time,
        $sampled(tx_phy0[1]), !$sampled(tx_phy0[1]));
    end

  a_stb_online: assert property (@(posedge clk_wr) disable iff (rst)
    tx_online_delay |=> tx_phy0[1])
    else begin
      fail_cnt++;
      $error("[FAIL] %0t tx_phy0[1] got %b exp 1", $time, $sampled(tx_phy0[1]));
    end

  ////////////////////////////////////////////////////////////
  // Data path, credits and status

  a_push_lanes: assert property (@(posedge clk_wr) disable iff (rst)
    tx_phy0[0] == hs_d2 &&
    (!hs_d2 || {tx_phy1, tx_phy0[PHY_W-1:2]} == (2 * PHY_W - 2)'(word_d2)))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t tx_phy0/tx_phy1 push,lanes got %b,%h exp %b,%h", $time,
        $sampled(tx_phy0[0]), $sampled({tx_phy1, tx_phy0[PHY_W-1:2]}),
        $sampled(hs_d2), $sampled(word_d2));
    end

  a_ready: assert property (@(posedge clk_wr) disable iff (rst)
    user_tready == (tx_online_delay && exp_cred != '0))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t user_tready got %b exp %b", $time, $sampled(user_tready),
        $sampled(tx_online_delay && exp_cred != '0));
    end

  a_status: assert property (@(posedge clk_wr) disable iff (rst)
    tx_st_debug_status == DBG_W'({tx_online_delay, exp_push, exp_cred}))
    else begin
      fail_cnt++;
      $error("[FAIL] %0t tx_st_debug_status got %h exp %h", $time,
        $sampled(tx_st_debug_status),
        $sampled(DBG_W'({tx_online_delay, exp_push, exp_cred})));
    end

endmodule

bind st_link_master_top st_link_master_asserts i_asserts (
  .clk_wr             (clk_wr),
  .rst                (rst),
  .tx_online          (tx_online),
  .rx_online          (rx_online),
  .tx_online_delay    (tx_online_delay),
  .rx_online_delay    (rx_online_delay),
  .init_st_credit     (init_st_credit),
  .delay_x_value      (delay_x_value),
  .delay_y_value      (delay_y_value),
  .user_word          ({user_tlast, user_tkeep, user_tdata}),
  .user_tvalid        (user_tvalid),
  .user_tready        (user_tready),
  .tx_phy0            (tx_phy0),
  .tx_phy1            (tx_phy1),
  .rx_phy0            (rx_phy0),
  .tx_st_debug_status (tx_st_debug_status)
);

// File: bench/tb_st_link_master.sv
////////////////////////////////////////////////////////////
// Link transmit testbench: clock, reset, stimulus,
// far-side receiver model, per-test report, timeout
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_st_link_master;
  import st_link_pkg::*;

  localparam int    MAX_CYCLES = 4000;
  localparam int    WAIT_LIMIT = 200;
  localparam dly_t  DLY_X      = 16'd12;
  localparam dly_t  DLY_Y      = 16'd9;
  localparam cred_t INIT_CRED  = 8'd3;

  logic             clk_wr;
  logic             rst;
  logic             tx_online;
  logic             rx_online;
  cred_t            init_st_credit;
  phy_t             tx_phy0;
  phy_t             rx_phy0;
  phy_t             tx_phy1;
  phy_t             rx_phy1;
  st_keep_t         user_tkeep;
  st_data_t         user_tdata;
  logic             user_tlast;
  logic             user_tvalid;
  logic             user_tready;
  logic [DBG_W-1:0] tx_st_debug_status;
  dly_t             delay_x_value;
  dly_t             delay_y_value;

  int unsigned      cycle_cnt = 0;
  int unsigned      tb_errs = 0;
  int unsigned      tests_run = 0;
  int unsigned      tests_bad = 0;
  int unsigned      fails_before = 0;
  int unsigned      sent_cnt = 0;
  int unsigned      last_due = 0;
  int unsigned      ret_idx = 0;
  int unsigned      due;
  int unsigned      dly_tab [64];
  logic             ret_pulse = 1'b0;
  logic             ret_en;
  logic             ok;
  st_word_t         rx_q [$];
  int unsigned      ret_q [$];

  // Credit return on bit 0, the rest of the channel idle
  assign rx_phy0 = {{(PHY_W - 1){1'b0}}, ret_pulse};

  st_link_master_top i_dut (
    .clk_wr             (clk_wr),
    .rst                (rst),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .init_st_credit     (init_st_credit),
    .tx_phy0            (tx_phy0),
    .rx_phy0            (rx_phy0),
    .tx_phy1            (tx_phy1),
    .rx_phy1            (rx_phy1),
    .user_tkeep         (user_tkeep),
    .user_tdata         (user_tdata),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .tx_st_debug_status (tx_st_debug_status),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value)
  );

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  always @(posedge clk_wr) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display("test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Far side

  // Decode each push, return its credit 1 to 4 cycles later
  always @(negedge clk_wr) begin
    if (tx_phy0[0]) begin
      rx_q.push_back(st_word_t'({tx_phy1[PHY1_WORD_W-1:0], tx_phy0[PHY_W-1:2]}));
      due = cycle_cnt + dly_tab[ret_idx % 64];
      ret_idx++;
      // One pulse per cycle at most
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      ret_q.push_back(due);
    end
    ret_pulse = 1'b0;
    if (ret_en && ret_q.size() > 0 && ret_q[0] <= cycle_cnt) begin
      ret_pulse = 1'b1;
      void'(ret_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers

  function automatic int unsigned total_fails();
    return tb_errs + i_dut.i_asserts.fail_cnt;
  endfunction

  function automatic st_word_t random_word();
    st_word_t w;
    for (int i = 0; i < DATA_W / 32; i++) begin
      w.data[i*32 +: 32] = $urandom;
    end
    w.keep  = $urandom;
    w.tlast = $urandom % 2;
    return w;
  endfunction

  // Valid stays up until the word is taken or the limit runs out
  task automatic send_word(input st_word_t w, input int unsigned limit, output logic taken);
    int unsigned n;
    n = 0;
    taken = 1'b0;
    user_tdata  = w.data;
    user_tkeep  = w.keep;
    user_tlast  = w.tlast;
    user_tvalid = 1'b1;
    while (!taken && n < limit) begin
      // Ready is stable in the low phase
      taken = user_tready;
      @(negedge clk_wr);
      n++;
    end
    if (taken) begin
      user_tvalid = 1'b0;
      sent_cnt++;
    end
  endtask

  task automatic send_stream(input int unsigned count, input int unsigned gap_max);
    logic taken;
    for (int i = 0; i < count; i++) begin
      send_word(random_word(), WAIT_LIMIT, taken);
      if (!taken) begin
        $display("Error at %0t: word %0d never accepted", $time, i);
        tb_errs++;
      end
      repeat ($urandom % (gap_max + 1)) @(negedge clk_wr);
    end
  endtask

  // All words seen at the far side and all credits back
  task automatic wait_far_side();
    int unsigned n;
    n = 0;
    while ((rx_q.size() != sent_cnt || ret_q.size() != 0) && n < WAIT_LIMIT) begin
      @(negedge clk_wr);
      n++;
    end
    if (rx_q.size() != sent_cnt || ret_q.size() != 0) begin
      $display("Error at %0t: far side got %0d of %0d words, %0d credits pending",
        $time, rx_q.size(), sent_cnt, ret_q.size());
      tb_errs++;
    end
    repeat (4) @(negedge clk_wr);
  endtask

  task automatic report_test(input string name);
    int unsigned now_fails;
    now_fails = total_fails();
    tests_run++;
    if (now_fails != fails_before) begin
      tests_bad++;
    end
    $display("%-22s %s", name, (now_fails == fails_before) ? "ok" : "errors");
    fails_before = now_fails;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    void'($urandom(32'h637f2792));
    foreach (dly_tab[i]) begin
      dly_tab[i] = 1 + ($urandom % 4);
    end
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_st_credit = INIT_CRED;
    rx_phy1        = '0;
    user_tkeep     = '0;
    user_tdata     = '0;
    user_tlast     = 1'b0;
    user_tvalid    = 1'b0;
    delay_x_value  = DLY_X;
    delay_y_value  = DLY_Y;
    ret_en         = 1'b0;
    repeat (2) @(posedge clk_wr);
    @(negedge clk_wr);
    rst = 1'b0;

    // Both sides come up, strobe pulses meanwhile
    rx_online = 1'b1;
    tx_online = 1'b1;
    for (int n = 0; n < WAIT_LIMIT && !user_tready; n++) begin
      @(negedge clk_wr);
    end
    if (!user_tready) begin
      $display("Error at %0t: user_tready never rose after online", $time);
      tb_errs++;
    end
    report_test("reset and online");
    repeat (STB_PERIOD) @(negedge clk_wr);
    report_test("alignment strobe");

    // Three credits, no returns, fourth word held back
    send_stream(3, 0);
    send_word(random_word(), 10, ok);
    ret_en = 1'b1;
    if (!ok) begin
      send_word({user_tlast, user_tkeep, user_tdata}, WAIT_LIMIT, ok);
    end
    if (!ok) begin
      $display("Error at %0t: transfer did not resume after credit return", $time);
      tb_errs++;
    end
    report_test("credits");

    send_stream(24, 2);
    wait_far_side();
    report_test("data path");

    // Back to back, takes and returns in the same cycle
    send_stream(12, 0);
    wait_far_side();
    report_test("debug status");

    // Drop online with valid held high
    tx_online = 1'b0;
    send_word(random_word(), 12, ok);
    send_word(random_word(), 12, ok);
    user_tvalid = 1'b0;
    rx_online   = 1'b0;
    repeat (2 * STB_PERIOD) @(negedge clk_wr);
    report_test("offline drop");

    $display("tests %0d, with errors %0d, assertion failures %0d, bench errors %0d",
      tests_run, tests_bad, i_dut.i_asserts.fail_cnt, tb_errs);
    if (total_fails() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: src.f
common/st_link_pkg.sv
ll/ll_auto_sync.sv
ll/ll_transmit.sv
verilog/st_phy_map.sv
verilog/st_link_master_top.sv
bench/st_link_master_asserts.sv
bench/tb_st_link_master.sv

// File: Bender.yml
package:
  name: st_link_master

sources:
  # Design
  - files:
      - common/st_link_pkg.sv
      - ll/ll_auto_sync.sv
      - ll/ll_transmit.sv
      - verilog/st_phy_map.sv
      - verilog/st_link_master_top.sv

  # Testbench
  - target: test
    files:
      - bench/st_link_master_asserts.sv
      - bench/tb_st_link_master.sv
